//--- sim.f
+incdir+tb
rtl/fp_pkg.sv
rtl/mul_pkg.sv
rtl/booth_multiplier.sv
rtl/fp_mul_stage1.sv
rtl/fp_norm_round.sv
rtl/fp_result_pack.sv
rtl/fp_mul_top.sv
tb/clk_gen.sv
tb/fp_mul_tb.sv

//--- Bender.yml
package:
  name: fp_mul

sources:
  - files:
      - rtl/fp_pkg.sv
      - rtl/mul_pkg.sv
      - rtl/booth_multiplier.sv
      - rtl/fp_mul_stage1.sv
      - rtl/fp_norm_round.sv
      - rtl/fp_result_pack.sv
      - rtl/fp_mul_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/clk_gen.sv
      - tb/fp_mul_tb.sv

//--- tb/fp_mul_model.svh
// Multiply reference model: classifies operands, rounds on the 48-bit integer product remainder
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

function automatic void model_mul(input logic [31:0] a, input logic [31:0] b,
                                  input rnd_mode_e mode, output logic [31:0] res,
                                  output logic [4:0] flg);
  logic        sign;
  logic        inf_a;
  logic        inf_b;
  logic        zero_a;
  logic        zero_b;
  logic        nan;
  logic        inf;
  logic        zero;
  logic        ovf;
  logic        udf;
  logic        up;
  logic [47:0] p;
  logic [47:0] keep;
  logic [47:0] rem;
  logic [47:0] half;
  int          e;

  sign   = a[31] ^ b[31];
  inf_a  = (a[30:23] == 8'hff) && (a[22:0] == 0);
  inf_b  = (b[30:23] == 8'hff) && (b[22:0] == 0);
  zero_a = (a[30:23] == 0);  // Subnormals count as zero
  zero_b = (b[30:23] == 0);
  nan    = ((a[30:23] == 8'hff) && (a[22:0] != 0)) || ((b[30:23] == 8'hff) && (b[22:0] != 0)) ||
           (inf_a && zero_b) || (inf_b && zero_a);
  inf    = inf_a || inf_b;
  zero   = zero_a || zero_b;

  p = {24'd0, 1'b1, a[22:0]} * {24'd0, 1'b1, b[22:0]};
  e = int'(a[30:23]) + int'(b[30:23]) - 127;
  if (p[47]) begin
    keep = p >> 24;
    rem  = p & 48'hff_ffff;
    half = 48'h80_0000;
    e++;
  end else begin
    keep = p >> 23;
    rem  = p & 48'h7f_ffff;
    half = 48'h40_0000;
  end

  case (mode)
    rne:     up = (rem > half) || ((rem == half) && keep[0]);
    rtz:     up = 1'b0;
    rdn:     up = sign && (rem != 0);
    rup:     up = !sign && (rem != 0);
    default: up = (rem >= half);
  endcase
  keep = keep + up;
  if (keep[24]) begin
    keep = keep >> 1;
    e++;
  end

  ovf = !(nan || inf || zero) && (e >= 255);
  udf = !(nan || inf || zero) && (e <= 0);
  if (nan) begin
    res = 32'h7fc0_0000;
  end else if (inf || ovf) begin
    res = {sign, 8'hff, 23'd0};
  end else if (zero || udf) begin
    res = {sign, 31'd0};
  end else begin
    res = {sign, e[7:0], keep[22:0]};
  end
  flg = {nan, inf && !nan, zero && !nan, ovf, udf};
endfunction

`endif

//--- tb/fp_mul_tb.sv
// Testbench for the pipelined single-precision multiplier with directed tests against a model
`timescale 1ns/1ps

module fp_mul_tb import fp_pkg::*, mul_pkg::*;;

  localparam int N_RAND       = 40;
  localparam int N_OPS        = 5 * N_RAND + 20 + 6 + 9 + 24;
  localparam int DRAIN_CYCLES = 6;
  localparam int LIMIT_CYCLES = N_OPS + 5 * DRAIN_CYCLES + 100;

  typedef struct {
    int          due;
    logic [31:0] res;
    logic [4:0]  flg;
  } expect_t;

  logic      clk;
  logic      rst;
  logic      in_valid;
  fp32_t     op_a;
  fp32_t     op_b;
  rnd_mode_e rnd_mode;
  logic      out_valid;
  fp32_t     result;
  fp_flags_t flags;

  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  logic [31:0] lfsr;
  logic [31:0] pair_a [N_RAND];
  logic [31:0] pair_b [N_RAND];
  expect_t     pending [$];

  `include "fp_mul_model.svh"

  clk_gen #(.PERIOD(8.0), .RST_CYCLES(5)) u_clk_gen (.clk(clk), .rst(rst));

  fp_mul_top uut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .op_a     (op_a),
    .op_b     (op_b),
    .rnd_mode (rnd_mode),
    .out_valid(out_valid),
    .result   (result),
    .flags    (flags)
  );

  always @(posedge clk) cycles <= cycles + 1;

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] normal_operand();
    logic        s;
    logic [7:0]  e;
    logic [22:0] f;
    s = lfsr_bits(1);
    e = 8'(64 + lfsr_bits(7) % 127);  // 64 to 190
    f = lfsr_bits(23);
    return {s, e, f};
  endfunction

  task automatic issue(input logic [31:0] a, input logic [31:0] b, input rnd_mode_e mode);
    expect_t     item;
    logic [31:0] res;
    logic [4:0]  flg;
    @(posedge clk);
    #1;
    in_valid = 1'b1;
    op_a     = a;
    op_b     = b;
    rnd_mode = mode;
    model_mul(a, b, mode, res, flg);
    item.due = cycles + 3;  // Result due three edges after this one
    item.res = res;
    item.flg = flg;
    pending.push_back(item);
  endtask

  task automatic idle();
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  task automatic drain();
    idle();
    while (pending.size() != 0) @(posedge clk);
  endtask

  // Output checks at mid-cycle
  always @(negedge clk) begin
    if (cycles > 0) begin
      if (pending.size() != 0 && pending[0].due == cycles) begin
        check("out_valid", 32'(out_valid), 32'd1);
        check("result", result, pending[0].res);
        check("flags", 32'(flags), 32'(pending[0].flg));
        void'(pending.pop_front());
      end else begin
        check("idle out_valid", 32'(out_valid), 32'd0);
        if (rst) begin
          check("reset flags", 32'(flags), 32'd0);
        end
      end
    end
  end

  task automatic rne_random();
    for (int i = 0; i < N_RAND; i++) begin
      pair_a[i] = normal_operand();
      pair_b[i] = normal_operand();
      issue(pair_a[i], pair_b[i], rne);
    end
    drain();
  endtask

  task automatic mode_sweep();
    for (int m = 1; m < 5; m++) begin
      for (int i = 0; i < N_RAND; i++) issue(pair_a[i], pair_b[i], rnd_mode_e'(3'(m)));
    end
    // Odd fraction times 1.5 leaves exactly half an ulp
    for (int m = 0; m < 5; m++) begin
      for (int s = 0; s < 2; s++) begin
        for (int j = 0; j < 2; j++) begin
          issue({1'(s), 8'd127, 23'(2 * j + 1)}, 32'h3fc0_0000, rnd_mode_e'(3'(m)));
        end
      end
    end
    drain();
  endtask

  task automatic range_limits();
    issue({1'b0, 8'd200, 23'h12_3456}, {1'b0, 8'd200, 23'h0}, rne);
    issue({1'b1, 8'd200, 23'h0}, {1'b0, 8'd200, 23'h7f_0000}, rtz);  // Still infinity
    issue({1'b0, 8'd254, 23'h0}, {1'b0, 8'd128, 23'h0}, rne);        // Exponent lands on 255
    issue({1'b0, 8'd20, 23'h55_5555}, {1'b0, 8'd30, 23'h0}, rne);
    issue({1'b1, 8'd1, 23'h0}, {1'b0, 8'd1, 23'h0}, rup);
    issue({1'b0, 8'd63, 23'h0}, {1'b0, 8'd64, 23'h0}, rne);          // Exponent lands on 0
    drain();
  endtask

  task automatic special_operands();
    issue(32'h7f80_0001, 32'h3f80_0000, rne);
    issue(32'h7f80_0000, 32'h0000_0000, rne);
    issue(32'h8000_0000, 32'hff80_0000, rne);
    issue(32'hff80_0000, 32'h4000_0000, rne);
    issue(32'h7f80_0000, 32'h7f80_0000, rup);
    issue(32'h0000_0000, 32'hc040_0000, rne);
    issue(32'h0000_0005, 32'h3f80_0000, rup);  // Subnormal flushed
    issue(32'h7fc0_0000, 32'h0000_0000, rne);
    issue(32'hffff_ffff, 32'h7f80_0000, rne);
    drain();
  endtask

  task automatic pipeline_stream();
    for (int i = 0; i < 24; i++) begin
      if (lfsr_bits(1)) begin
        issue(normal_operand(), normal_operand(), rnd_mode_e'(3'(lfsr_bits(3) % 5)));
      end else begin
        idle();
      end
    end
    drain();
  endtask

  initial begin
    #(LIMIT_CYCLES * 8);
    $display("watchdog expired before the tests completed");
    $display("tests failed");
    $finish;
  end

  initial begin
    in_valid = 1'b0;
    op_a     = '0;
    op_b     = '0;
    rnd_mode = rne;
    lfsr     = 32'd97128;
    @(negedge rst);
    rne_random();
    mode_sweep();
    range_limits();
    special_operands();
    pipeline_stream();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- tb/clk_gen.sv
// Testbench clock and reset source, 8 ns clock with a 5-cycle synchronous reset
`timescale 1ns/1ps

module clk_gen #(
  parameter realtime PERIOD     = 8.0,
  parameter int      RST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1 rst = 1'b0;  // Released off the edge, like the stimulus
  end

endmodule

//--- rtl/fp_mul_top.sv
// Pipelined single-precision multiplier, three stages, one operation per cycle
`timescale 1ns/1ps

module fp_mul_top import fp_pkg::*, mul_pkg::*; #(
  parameter int SIG_W = fp_pkg::SIG_W
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  fp32_t     op_a,
  input  fp32_t     op_b,
  input  rnd_mode_e rnd_mode,
  output logic      out_valid,
  output fp32_t     result,
  output fp_flags_t flags
);

  s1_t s1;
  s2_t s2;

  fp_mul_stage1 #(.SIG_W(SIG_W)) u_stage1 (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .op_a    (op_a),
    .op_b    (op_b),
    .rnd_mode(rnd_mode),
    .s1      (s1)
  );

  fp_norm_round u_norm_round (
    .clk(clk),
    .rst(rst),
    .s1 (s1),
    .s2 (s2)
  );

  fp_result_pack u_result_pack (
    .clk      (clk),
    .rst      (rst),
    .s2       (s2),
    .out_valid(out_valid),
    .result   (result),
    .flags    (flags)
  );

endmodule

//--- rtl/fp_result_pack.sv
// Multiplier stage 3: exception priority, result word and flags, output register
`timescale 1ns/1ps

module fp_result_pack import fp_pkg::*, mul_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  s2_t       s2,
  output logic      out_valid,
  output fp32_t     result,
  output fp_flags_t flags
);

  fp32_t     result_d;
  fp_flags_t flags_d;

  always_comb begin
    if (s2.cls.nan) begin
      result_d = QNAN;
    end else if (s2.cls.inf || s2.ovf) begin
      result_d = {s2.sign, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
    end else if (s2.cls.zero || s2.udf) begin
      result_d = {s2.sign, {EXP_W{1'b0}}, {FRAC_W{1'b0}}};
    end else begin
      result_d = {s2.sign, s2.exp, s2.frac};
    end
  end

  // inf and zero follow the operand class; range faults have their own bits
  assign flags_d.nan  = s2.cls.nan;
  assign flags_d.inf  = s2.cls.inf && !s2.cls.nan;
  assign flags_d.zero = s2.cls.zero && !s2.cls.nan;
  assign flags_d.ovf  = s2.ovf;
  assign flags_d.udf  = s2.udf;

  always_ff @(posedge clk) begin
    result <= result_d;
    if (rst) begin
      out_valid <= 1'b0;
      flags     <= '0;
    end else begin
      out_valid <= s2.valid;
      flags     <= flags_d;
    end
  end

  // NaN class from stage 1 must suppress the range check of stage 2
  a_nan_ovf: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> !(flags.nan && flags.ovf))
    else $error("nan and ovf flagged together");

endmodule

//--- rtl/fp_norm_round.sv
// Multiplier stage 2: normalize, round per mode, adjust exponent and check range
`timescale 1ns/1ps

module fp_norm_round import fp_pkg::*, mul_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  s1_t  s1,
  output s2_t  s2
);

  logic              top;
  logic [SIG_W-1:0]  mant;
  logic              guard;
  logic              sticky;
  logic              inc;
  logic              carry;
  logic              special;
  logic [SIG_W:0]    rounded;
  logic [FRAC_W-1:0] frac;
  logic signed [9:0] exp_n;
  logic signed [9:0] exp_r;
  s2_t               s2_d;

  assign top = s1.prod[PROD_W-1];  // Product in [2,4)

  assign mant   = top ? s1.prod[PROD_W-1 -: SIG_W] : s1.prod[PROD_W-2 -: SIG_W];
  assign guard  = top ? s1.prod[PROD_W-1-SIG_W] : s1.prod[PROD_W-2-SIG_W];
  assign sticky = top ? |s1.prod[PROD_W-2-SIG_W:0] : |s1.prod[PROD_W-3-SIG_W:0];
  assign exp_n  = s1.exp_sum + $signed({9'd0, top});

  always_comb begin
    case (s1.rnd_mode)
      rne:     inc = guard && (sticky || mant[0]);
      rtz:     inc = 1'b0;
      rdn:     inc = s1.sign && (guard || sticky);
      rup:     inc = !s1.sign && (guard || sticky);
      rmm:     inc = guard;
      default: inc = 1'b0;
    endcase
  end

  assign rounded = {1'b0, mant} + {{SIG_W{1'b0}}, inc};
  assign carry   = rounded[SIG_W];  // All ones rounded up to 10.0
  assign frac    = carry ? rounded[SIG_W-1:1] : rounded[SIG_W-2:0];
  assign exp_r   = exp_n + $signed({9'd0, carry});

  assign special = s1.cls.nan || s1.cls.inf || s1.cls.zero;

  always_comb begin
    s2_d.valid = s1.valid;
    s2_d.cls   = s1.cls;
    s2_d.sign  = s1.sign;
    s2_d.exp   = exp_r[EXP_W-1:0];
    s2_d.frac  = frac;
    // Range only matters for finite nonzero operands
    s2_d.ovf   = !special && (exp_r >= EXP_MAX);
    s2_d.udf   = !special && (exp_r <= 0);
  end

  always_ff @(posedge clk) begin
    s2 <= s2_d;
    if (rst) begin
      s2.valid <= 1'b0;
    end
  end

  // Stage 1 must hand over a product in [1,4) for every ordinary operation
  a_lead_bit: assert property (@(posedge clk) disable iff (rst)
    (s1.valid && !special) |-> mant[SIG_W-1])
    else $error("leading significand bit clear after normalization");

endmodule

//--- rtl/fp_mul_stage1.sv
// Multiplier stage 1: operand unpack and classification, exponent sum, significand product
`timescale 1ns/1ps

module fp_mul_stage1 import fp_pkg::*, mul_pkg::*; #(
  parameter int SIG_W = fp_pkg::SIG_W
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  fp32_t     op_a,
  input  fp32_t     op_b,
  input  rnd_mode_e rnd_mode,
  output s1_t       s1
);

  logic [SIG_W-1:0]   sig_a;
  logic [SIG_W-1:0]   sig_b;
  logic [2*SIG_W-1:0] prod;
  logic               nan_a, nan_b, inf_a, inf_b, zero_a, zero_b;
  logic signed [9:0]  exp_sum;
  fp_class_t          cls;
  s1_t                s1_d;

  assign nan_a  = (&op_a.exp) && (|op_a.frac);
  assign nan_b  = (&op_b.exp) && (|op_b.frac);
  assign inf_a  = (&op_a.exp) && !(|op_a.frac);
  assign inf_b  = (&op_b.exp) && !(|op_b.frac);
  assign zero_a = (op_a.exp == '0);  // Subnormals flush to zero
  assign zero_b = (op_b.exp == '0);

  assign cls.nan  = nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a);
  assign cls.inf  = inf_a || inf_b;
  assign cls.zero = zero_a || zero_b;

  assign sig_a = {|op_a.exp, op_a.frac};
  assign sig_b = {|op_b.exp, op_b.frac};

  assign exp_sum = 10'(op_a.exp) + 10'(op_b.exp) - 10'(BIAS);

  booth_multiplier #(.SIG_W(SIG_W)) u_booth (
    .a      (sig_a),
    .b      (sig_b),
    .product(prod)
  );

  always_comb begin
    s1_d.valid    = in_valid;
    s1_d.sign     = op_a.sign ^ op_b.sign;
    s1_d.rnd_mode = rnd_mode;
    s1_d.cls      = cls;
    s1_d.exp_sum  = exp_sum;
    s1_d.prod     = prod;
  end

  always_ff @(posedge clk) begin
    s1 <= s1_d;
    if (rst) begin
      s1.valid <= 1'b0;
    end
  end

endmodule

//--- rtl/booth_multiplier.sv
// Radix-8 Booth significand multiplier, unsigned operands, full-width product
`timescale 1ns/1ps

module booth_multiplier import fp_pkg::*; #(
  parameter int SIG_W = FRAC_W + 1
) (
  input  logic [SIG_W-1:0]   a,
  input  logic [SIG_W-1:0]   b,
  output logic [2*SIG_W-1:0] product
);

  localparam int PW = 2 * SIG_W;
  localparam int ND = (SIG_W + 3) / 3;  // Digits, incl. a zero sign bit

  logic [3*ND:0] a_ext;
  logic [PW-1:0] b1;
  logic [PW-1:0] b2;
  logic [PW-1:0] b3;
  logic [PW-1:0] b4;
  logic [PW-1:0] row [ND];
  logic [PW-1:0] acc [ND];

  assign a_ext = {{(3*ND-SIG_W){1'b0}}, a, 1'b0};

  assign b1 = {{SIG_W{1'b0}}, b};
  assign b2 = b1 << 1;
  assign b3 = b1 + b2;  // The one hard multiple
  assign b4 = b1 << 2;

  for (genvar i = 0; i < ND; i++) begin : g_row
    logic [3:0]    grp;
    logic [2:0]    sel;
    logic [PW-1:0] mag;

    assign grp = a_ext[3*i +: 4];
    // Negative digits fold onto the same magnitude table
    assign sel = grp[3] ? ~grp[2:0] : grp[2:0];

    always_comb begin
      case (sel)
        3'd0:       mag = '0;
        3'd1, 3'd2: mag = b1;
        3'd3, 3'd4: mag = b2;
        3'd5, 3'd6: mag = b3;
        default:    mag = b4;
      endcase
    end

    // Full-width two's complement gives the sign extension
    assign row[i] = (grp[3] ? -mag : mag) << (3 * i);
  end

  for (genvar i = 0; i < ND; i++) begin : g_sum
    if (i == 0) begin : g_first
      assign acc[i] = row[i];
    end else begin : g_add
      assign acc[i] = acc[i-1] + row[i];
    end
  end

  assign product = acc[ND-1];

  // Two normalized significands always land in [2^(PW-2), 2^PW)
  a_top_pair: assert final ($isunknown({a, b}) || !(a[SIG_W-1] && b[SIG_W-1]) ||
                            product[PW-1 -: 2] != 2'b00)
    else $error("booth product below normalized range");

endmodule

//--- rtl/mul_pkg.sv
// Multiplier pipeline payloads between stages and the result flags
package mul_pkg;

  import fp_pkg::*;

  typedef struct packed {
    logic nan;
    logic inf;
    logic zero;
    logic ovf;
    logic udf;
  } fp_flags_t;

  // Stage 1 to stage 2
  typedef struct packed {
    logic               valid;
    logic               sign;
    rnd_mode_e          rnd_mode;
    fp_class_t          cls;
    logic signed [9:0]  exp_sum;  // ea + eb - BIAS
    logic [PROD_W-1:0]  prod;
  } s1_t;

  // Stage 2 to output stage
  typedef struct packed {
    logic              valid;
    fp_class_t         cls;
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
    logic              ovf;
    logic              udf;
  } s2_t;

endpackage

//--- rtl/fp_pkg.sv
// IEEE-754 single-precision format: field constants, word layout, rounding modes, operand class
package fp_pkg;

  localparam int EXP_W   = 8;
  localparam int FRAC_W  = 23;
  localparam int SIG_W   = 24;   // Fraction plus hidden bit
  localparam int PROD_W  = 48;
  localparam int BIAS    = 127;
  localparam int EXP_MAX = 255;  // All-ones exponent

  // Sign, biased exponent, fraction
  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp32_t;

  // Canonical quiet NaN
  localparam fp32_t QNAN = 32'h7FC0_0000;

  typedef enum logic [2:0] {
    rne = 3'd0,  // Nearest, ties to even
    rtz = 3'd1,  // Toward zero
    rdn = 3'd2,  // Toward minus infinity
    rup = 3'd3,  // Toward plus infinity
    rmm = 3'd4   // Nearest, ties away from zero
  } rnd_mode_e;

  // Class of an operand pair, not of a single operand
  typedef struct packed {
    logic nan;
    logic inf;
    logic zero;
  } fp_class_t;

endpackage
